/* source/cpu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared encodings for the five-stage core
// Opcode values outside opcode_e decode as no register write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_jr    = 6'h08,
		op_jalr  = 6'h09,
		op_addi  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} alu_func_e;

	typedef enum logic [1:0] {
		wb_alu  = 2'd0,
		wb_load = 2'd1,
		wb_link = 2'd2
	} wb_src_e;

endpackage

`default_nettype wire

/* source/cpu_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage with pc reset to 0 and one delay slot
// Jump wins over branch when both are asserted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cpu_if
	import cpu_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            br_taken,
	input  logic            jmp_taken,
	input  logic [xlen-1:0] baddr,
	input  logic [xlen-1:0] jaddr,
	output logic [xlen-1:0] if_pc
);

	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] pc_seq;
	logic            redir;
	logic [xlen-1:0] redir_addr;

	assign pc_seq = if_pc + xlen'(4);

	// Target held one cycle so the next sequential
	// instruction runs as the delay slot
	always_comb begin
		if (redir) begin
			pc_next = redir_addr;
		end else begin
			pc_next = pc_seq;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			if_pc <= '0;
			redir <= 1'b0;
		end else begin
			if_pc <= pc_next;
			redir <= jmp_taken || br_taken;
		end

		if (jmp_taken) begin
			redir_addr <= jaddr;
		end else begin
			redir_addr <= baddr;
		end
	end

endmodule

`default_nettype wire

/* source/cpu_id.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage, no forwarding from later stages
// Register file reads are combinational, writes land at the edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cpu_id
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       if_pc,
	input  logic [xlen-1:0]       if_inst,
	input  logic                  wb_rfw,
	input  logic [reg_addr_w-1:0] wb_rf_waddr,
	input  logic [xlen-1:0]       wb_rf_wdata,
	output logic [xlen-1:0]       p_rfa,
	output logic [xlen-1:0]       p_rfb,
	output logic [xlen-1:0]       p_rfbse,
	output logic [4:0]            p_shamt,
	output alu_func_e             p_func,
	output logic [reg_addr_w-1:0] p_rf_waddr,
	output logic [xlen-1:0]       p_jalra,
	output logic                  p_c_rfw,
	output wb_src_e               p_c_wbsource,
	output logic                  p_c_drw,
	output opcode_e               p_c_alucontrol,
	output logic [xlen-1:0]       baddr,
	output logic [xlen-1:0]       jaddr,
	output logic                  br_taken,
	output logic                  jmp_taken
);

	localparam logic [1:0] dest_rd = 2'd0;
	localparam logic [1:0] dest_rt = 2'd1;
	localparam logic [1:0] dest_ra = 2'd2;

	// Register 0 has no storage
	logic [xlen-1:0] rf [31:1];

	opcode_e               opcode;
	logic [reg_addr_w-1:0] rs;
	logic [reg_addr_w-1:0] rt;
	logic [reg_addr_w-1:0] rd;
	logic [15:0]           imm;
	logic [xlen-1:0]       rs_val;
	logic [xlen-1:0]       rt_val;
	logic [xlen-1:0]       imm_ext;
	logic [reg_addr_w-1:0] rf_waddr;

	logic    c_rfw;
	wb_src_e c_wbsource;
	logic    c_drw;
	logic    c_zext;
	logic [1:0] dest_sel;

	assign opcode = opcode_e'(if_inst[31:26]);
	assign rs = if_inst[25:21];
	assign rt = if_inst[20:16];
	assign rd = if_inst[15:11];
	assign imm = if_inst[15:0];

	assign rs_val = (rs == '0) ? '0 : rf[rs];
	assign rt_val = (rt == '0) ? '0 : rf[rt];

	always_comb begin
		c_rfw = 1'b0;
		c_wbsource = wb_alu;
		c_drw = 1'b0;
		c_zext = 1'b0;
		dest_sel = dest_rt;
		case (opcode)
			op_rtype: begin
				c_rfw = 1'b1;
				dest_sel = dest_rd;
			end
			op_jal: begin
				c_rfw = 1'b1;
				c_wbsource = wb_link;
				dest_sel = dest_ra;
			end
			op_jalr: begin
				c_rfw = 1'b1;
				c_wbsource = wb_link;
			end
			op_lw: begin
				c_rfw = 1'b1;
				c_wbsource = wb_load;
			end
			op_sw: c_drw = 1'b1;
			op_andi, op_ori: begin
				c_rfw = 1'b1;
				c_zext = 1'b1;
			end
			op_addi, op_lui: c_rfw = 1'b1;
			default: ;
		endcase
	end

	assign imm_ext = c_zext ? {16'b0, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		case (dest_sel)
			dest_rd: rf_waddr = rd;
			dest_ra: rf_waddr = 5'd31;
			default: rf_waddr = rt;
		endcase
	end

	// Branch and jump resolution, one delay slot
	assign br_taken = (opcode == op_beq && rs_val == rt_val) ||
		(opcode == op_bne && rs_val != rt_val);
	assign jmp_taken = opcode inside {op_j, op_jal, op_jr, op_jalr};
	assign baddr = if_pc + xlen'(4) + {{14{imm[15]}}, imm, 2'b00};
	assign jaddr = (opcode == op_j || opcode == op_jal) ?
		{if_pc[31:28], if_inst[25:0], 2'b00} : rs_val;

	always_ff @(posedge clk) begin
		if (rst) begin
			p_c_rfw <= 1'b0;
			p_c_wbsource <= wb_alu;
			p_c_drw <= 1'b0;
			p_c_alucontrol <= op_rtype;
		end else begin
			p_c_rfw <= c_rfw;
			p_c_wbsource <= c_wbsource;
			p_c_drw <= c_drw;
			p_c_alucontrol <= opcode;
		end

		p_rfa <= rs_val;
		p_rfb <= rt_val;
		p_rfbse <= (opcode == op_rtype) ? rt_val : imm_ext;
		p_shamt <= if_inst[10:6];
		p_func <= alu_func_e'(if_inst[5:0]);
		p_rf_waddr <= rf_waddr;
		p_jalra <= if_pc + xlen'(8);

		if (wb_rfw && wb_rf_waddr != '0) begin
			rf[wb_rf_waddr] <= wb_rf_wdata;
		end
	end

endmodule

`default_nettype wire

/* source/cpu_ex.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage, no overflow detection on add or sub
// Unlisted opcodes and functions give a zero result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cpu_ex
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       p_rfa,
	input  logic [xlen-1:0]       p_rfb,
	input  logic [xlen-1:0]       p_rfbse,
	input  logic [4:0]            p_shamt,
	input  alu_func_e             p_func,
	input  logic [reg_addr_w-1:0] p_rf_waddr,
	input  logic [xlen-1:0]       p_jalra,
	input  logic                  p_c_rfw,
	input  wb_src_e               p_c_wbsource,
	input  logic                  p_c_drw,
	input  opcode_e               p_c_alucontrol,
	output logic [xlen-1:0]       x_alu,
	output logic [xlen-1:0]       x_store_data,
	output logic [reg_addr_w-1:0] x_rf_waddr,
	output logic [xlen-1:0]       x_jalra,
	output logic                  x_c_rfw,
	output wb_src_e               x_c_wbsource,
	output logic                  x_c_drw
);

	logic [xlen-1:0] rtype_res;
	logic [xlen-1:0] alu_res;

	always_comb begin
		case (p_func)
			fn_sll: rtype_res = p_rfb << p_shamt;
			fn_srl: rtype_res = p_rfb >> p_shamt;
			fn_add: rtype_res = p_rfa + p_rfbse;
			fn_sub: rtype_res = p_rfa - p_rfbse;
			fn_and: rtype_res = p_rfa & p_rfbse;
			fn_or:  rtype_res = p_rfa | p_rfbse;
			fn_slt: rtype_res = {31'b0, $signed(p_rfa) < $signed(p_rfbse)};
			default: rtype_res = '0;
		endcase
	end

	// Loads and stores use the adder for the byte address
	always_comb begin
		case (p_c_alucontrol)
			op_rtype: alu_res = rtype_res;
			op_addi, op_lw, op_sw: alu_res = p_rfa + p_rfbse;
			op_andi: alu_res = p_rfa & p_rfbse;
			op_ori: alu_res = p_rfa | p_rfbse;
			op_lui: alu_res = {p_rfbse[15:0], 16'b0};
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			x_c_rfw <= 1'b0;
			x_c_wbsource <= wb_alu;
			x_c_drw <= 1'b0;
		end else begin
			x_c_rfw <= p_c_rfw;
			x_c_wbsource <= p_c_wbsource;
			x_c_drw <= p_c_drw;
		end

		x_alu <= alu_res;
		x_store_data <= p_rfb;
		x_rf_waddr <= p_rf_waddr;
		x_jalra <= p_jalra;
	end

endmodule

`default_nettype wire

/* source/cpu_mem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage, word access only, dmem_words a power of two
// Address bits above the RAM depth and the low two bits are ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cpu_mem
	import cpu_pkg::*;
#(
	parameter int dmem_words = 256
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       x_alu,
	input  logic [xlen-1:0]       x_store_data,
	input  logic [reg_addr_w-1:0] x_rf_waddr,
	input  logic [xlen-1:0]       x_jalra,
	input  logic                  x_c_rfw,
	input  wb_src_e               x_c_wbsource,
	input  logic                  x_c_drw,
	output logic                  wb_rfw,
	output logic [reg_addr_w-1:0] wb_rf_waddr,
	output logic [xlen-1:0]       wb_rf_wdata
);

	localparam int aw = $clog2(dmem_words);

	logic [xlen-1:0] dmem [dmem_words];

	logic [aw-1:0]   word_addr;
	logic [xlen-1:0] load_data;
	logic [xlen-1:0] wb_data;

	assign word_addr = x_alu[aw+1:2];
	assign load_data = dmem[word_addr];

	always_comb begin
		case (x_c_wbsource)
			wb_load: wb_data = load_data;
			wb_link: wb_data = x_jalra;
			default: wb_data = x_alu;
		endcase
	end

	always_ff @(posedge clk) begin
		if (x_c_drw) begin
			dmem[word_addr] <= x_store_data;
		end
	end

	// Writeback register, strobe seen by decode and the ports
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_rfw <= 1'b0;
		end else begin
			wb_rfw <= x_c_rfw;
		end

		wb_rf_waddr <= x_rf_waddr;
		wb_rf_wdata <= wb_data;
	end

endmodule

`default_nettype wire

/* source/cpu_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top, imem_data must follow imem_addr in the same cycle
// No interlocks, keep three instructions between dependent ones
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cpu_top
	import cpu_pkg::*;
#(
	parameter int dmem_words = 256
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [xlen-1:0]       imem_data,
	output logic [xlen-1:0]       imem_addr,
	output logic                  wb_rfw,
	output logic [reg_addr_w-1:0] wb_rf_waddr,
	output logic [xlen-1:0]       wb_rf_wdata
);

	logic [xlen-1:0] baddr;
	logic [xlen-1:0] jaddr;
	logic            br_taken;
	logic            jmp_taken;

	logic [xlen-1:0]       p_rfa;
	logic [xlen-1:0]       p_rfb;
	logic [xlen-1:0]       p_rfbse;
	logic [4:0]            p_shamt;
	alu_func_e             p_func;
	logic [reg_addr_w-1:0] p_rf_waddr;
	logic [xlen-1:0]       p_jalra;
	logic                  p_c_rfw;
	wb_src_e               p_c_wbsource;
	logic                  p_c_drw;
	opcode_e               p_c_alucontrol;

	logic [xlen-1:0]       x_alu;
	logic [xlen-1:0]       x_store_data;
	logic [reg_addr_w-1:0] x_rf_waddr;
	logic [xlen-1:0]       x_jalra;
	logic                  x_c_rfw;
	wb_src_e               x_c_wbsource;
	logic                  x_c_drw;

	cpu_if i_cpu_if (
		.clk       (clk),
		.rst       (rst),
		.br_taken  (br_taken),
		.jmp_taken (jmp_taken),
		.baddr     (baddr),
		.jaddr     (jaddr),
		.if_pc     (imem_addr)
	);

	cpu_id i_cpu_id (
		.clk            (clk),
		.rst            (rst),
		.if_pc          (imem_addr),
		.if_inst        (imem_data),
		.wb_rfw         (wb_rfw),
		.wb_rf_waddr    (wb_rf_waddr),
		.wb_rf_wdata    (wb_rf_wdata),
		.p_rfa          (p_rfa),
		.p_rfb          (p_rfb),
		.p_rfbse        (p_rfbse),
		.p_shamt        (p_shamt),
		.p_func         (p_func),
		.p_rf_waddr     (p_rf_waddr),
		.p_jalra        (p_jalra),
		.p_c_rfw        (p_c_rfw),
		.p_c_wbsource   (p_c_wbsource),
		.p_c_drw        (p_c_drw),
		.p_c_alucontrol (p_c_alucontrol),
		.baddr          (baddr),
		.jaddr          (jaddr),
		.br_taken       (br_taken),
		.jmp_taken      (jmp_taken)
	);

	cpu_ex i_cpu_ex (
		.clk            (clk),
		.rst            (rst),
		.p_rfa          (p_rfa),
		.p_rfb          (p_rfb),
		.p_rfbse        (p_rfbse),
		.p_shamt        (p_shamt),
		.p_func         (p_func),
		.p_rf_waddr     (p_rf_waddr),
		.p_jalra        (p_jalra),
		.p_c_rfw        (p_c_rfw),
		.p_c_wbsource   (p_c_wbsource),
		.p_c_drw        (p_c_drw),
		.p_c_alucontrol (p_c_alucontrol),
		.x_alu          (x_alu),
		.x_store_data   (x_store_data),
		.x_rf_waddr     (x_rf_waddr),
		.x_jalra        (x_jalra),
		.x_c_rfw        (x_c_rfw),
		.x_c_wbsource   (x_c_wbsource),
		.x_c_drw        (x_c_drw)
	);

	cpu_mem #(
		.dmem_words (dmem_words)
	) i_cpu_mem (
		.clk          (clk),
		.rst          (rst),
		.x_alu        (x_alu),
		.x_store_data (x_store_data),
		.x_rf_waddr   (x_rf_waddr),
		.x_jalra      (x_jalra),
		.x_c_rfw      (x_c_rfw),
		.x_c_wbsource (x_c_wbsource),
		.x_c_drw      (x_c_drw),
		.wb_rfw       (wb_rfw),
		.wb_rf_waddr  (wb_rf_waddr),
		.wb_rf_wdata  (wb_rf_wdata)
	);

endmodule

`default_nettype wire

/* sim/cpu_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for cpu_top, programs end in a jump-to-self loop
// Test programs keep three instructions between a write and a read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
();

	localparam int timeout_cycles = 3000;
	// add r0, r0, r0
	localparam logic [31:0] nop_word = 32'h0000_0020;

	logic        clk;
	logic        rst;
	logic [31:0] imem_data;
	logic [31:0] imem_addr;
	logic        wb_rfw;
	logic [4:0]  wb_rf_waddr;
	logic [31:0] wb_rf_wdata;

	logic [31:0] prog [256];
	logic [4:0]  exp_addr [$];
	logic [31:0] exp_data [$];
	string       test_name;
	int          pc_idx;
	int          got_count;
	int          cycles;
	integer      seed;

	cpu_top #(
		.dmem_words (256)
	) i_cpu_top (
		.clk         (clk),
		.rst         (rst),
		.imem_data   (imem_data),
		.imem_addr   (imem_addr),
		.wb_rfw      (wb_rfw),
		.wb_rf_waddr (wb_rf_waddr),
		.wb_rf_wdata (wb_rf_wdata)
	);

	// Instruction ROM, answers in the same cycle
	assign imem_data = (imem_addr[31:10] == '0) ? prog[imem_addr[9:2]] : nop_word;

	always #4 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			fail_run($sformatf("Timeout, run did not end within %0d cycles", timeout_cycles));
		end
	end

	// Writeback monitor, writes to r0 are not architectural
	always @(posedge clk) begin
		if (wb_rfw && wb_rf_waddr != '0) begin
			assert (got_count < exp_addr.size()) else
				fail_run($sformatf("Test %s wrote r%0d after all %0d expected writes",
					test_name, wb_rf_waddr, exp_addr.size()));
			assert (wb_rf_waddr == exp_addr[got_count]) else
				fail_run($sformatf("Error %s write %0d: expected r%0d actual r%0d",
					test_name, got_count, exp_addr[got_count], wb_rf_waddr));
			assert (wb_rf_wdata == exp_data[got_count]) else
				fail_run($sformatf("Error %s write %0d: expected %h actual %h",
					test_name, got_count, exp_data[got_count], wb_rf_wdata));
			got_count++;
		end
	end

	function automatic logic [31:0] rtype_word(input alu_func_e fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {op_rtype, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] itype_word(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Target given as a word index
	function automatic logic [31:0] jump_word(input opcode_e op, input int idx);
		return {op, 26'(idx)};
	endfunction

	function automatic logic [31:0] jreg_word(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt);
		return {op, rs, rt, 16'h0000};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[pc_idx] <= w;
		pc_idx++;
	endtask

	task automatic pad_nops(input int n);
		repeat (n) emit(nop_word);
	endtask

	task automatic want_write(input logic [4:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic imm_op(input opcode_e op, input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm, input logic [31:0] result);
		emit(itype_word(op, rs, rt, imm));
		if (rt != '0) begin
			want_write(rt, result);
		end
	endtask

	task automatic reg_op(input alu_func_e fn, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] shamt, input logic [31:0] result);
		emit(rtype_word(fn, rd, rs, rt, shamt));
		if (rd != '0) begin
			want_write(rd, result);
		end
	endtask

	// Holds the core in reset while the new program is loaded
	task automatic start_test(input string name);
		@(posedge clk);
		rst <= 1'b1;
		foreach (prog[i]) prog[i] <= nop_word;
		test_name = name;
		pc_idx = 0;
		got_count = 0;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic finish_test();
		logic [31:0] halt_pc;
		halt_pc = 32'(pc_idx * 4);
		emit(jump_word(op_j, pc_idx));
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		do @(posedge clk); while (imem_addr != halt_pc);
		// Drain the instructions still in the pipeline
		repeat (6) @(posedge clk);
		assert (got_count == exp_addr.size()) else
			fail_run($sformatf("Test %s saw %0d register writes but expected %0d",
				test_name, got_count, exp_addr.size()));
	endtask

	task automatic alu_ops();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		start_test("alu");
		a = 32'hFFFF_FED4;
		b = 32'h0000_0123;
		c = {16'hA5A5, 16'h0000};
		d = {16'h0000, 16'h8F0F};
		imm_op(op_addi, 1, 0, 16'hFED4, a);
		imm_op(op_addi, 2, 0, 16'h0123, b);
		imm_op(op_lui, 3, 0, 16'hA5A5, c);
		imm_op(op_ori, 4, 0, 16'h8F0F, d);
		pad_nops(3);
		reg_op(fn_add, 5, 1, 2, 0, a + b);
		reg_op(fn_sub, 6, 1, 2, 0, a - b);
		reg_op(fn_and, 7, 2, 4, 0, b & d);
		reg_op(fn_or, 8, 3, 4, 0, c | d);
		reg_op(fn_slt, 9, 1, 2, 0, 32'd1);
		reg_op(fn_slt, 10, 2, 1, 0, 32'd0);
		reg_op(fn_sll, 11, 0, 2, 4, b << 4);
		reg_op(fn_srl, 12, 0, 3, 8, c >> 8);
		imm_op(op_andi, 13, 1, 16'hF0F0, a & 32'h0000_F0F0);
		imm_op(op_ori, 14, 2, 16'h8000, b | 32'h0000_8000);
		imm_op(op_addi, 15, 1, 16'hFFFF, a - 32'd1);
		finish_test();
	endtask

	task automatic memory_access();
		start_test("memory");
		imm_op(op_addi, 1, 0, 16'h0111, 32'h0000_0111);
		imm_op(op_lui, 2, 0, 16'hDEAD, 32'hDEAD_0000);
		imm_op(op_ori, 3, 0, 16'hBEEF, 32'h0000_BEEF);
		imm_op(op_addi, 4, 0, 16'hFFFE, 32'hFFFF_FFFE);
		imm_op(op_addi, 5, 0, 16'h0040, 32'h0000_0040);
		pad_nops(3);
		emit(itype_word(op_sw, 5, 1, 16'h0000));
		emit(itype_word(op_sw, 5, 2, 16'h0004));
		emit(itype_word(op_sw, 5, 3, 16'h0008));
		emit(itype_word(op_sw, 5, 4, 16'hFFFC));
		emit(itype_word(op_sw, 0, 2, 16'h0200));
		imm_op(op_lw, 6, 5, 16'h0008, 32'h0000_BEEF);
		imm_op(op_lw, 7, 5, 16'hFFFC, 32'hFFFF_FFFE);
		imm_op(op_lw, 8, 0, 16'h0200, 32'hDEAD_0000);
		imm_op(op_lw, 9, 5, 16'h0004, 32'hDEAD_0000);
		imm_op(op_lw, 10, 5, 16'h0000, 32'h0000_0111);
		finish_test();
	endtask

	task automatic cond_branches();
		start_test("branch");
		imm_op(op_addi, 1, 0, 16'd5, 32'd5);
		imm_op(op_addi, 2, 0, 16'd5, 32'd5);
		imm_op(op_addi, 3, 0, 16'd7, 32'd7);
		pad_nops(3);
		// Taken, skips two after the delay slot
		emit(itype_word(op_beq, 1, 2, 16'd3));
		imm_op(op_addi, 4, 0, 16'd1, 32'd1);
		emit(itype_word(op_addi, 0, 5, 16'd99));
		emit(itype_word(op_addi, 0, 5, 16'd98));
		emit(itype_word(op_bne, 1, 3, 16'd2));
		imm_op(op_addi, 6, 0, 16'd2, 32'd2);
		emit(itype_word(op_addi, 0, 7, 16'd97));
		// Not taken
		emit(itype_word(op_beq, 1, 3, 16'd5));
		imm_op(op_addi, 8, 0, 16'd3, 32'd3);
		imm_op(op_addi, 9, 0, 16'd4, 32'd4);
		emit(itype_word(op_bne, 1, 2, 16'd5));
		imm_op(op_addi, 10, 0, 16'd5, 32'd5);
		imm_op(op_addi, 11, 0, 16'd6, 32'd6);
		// Countdown loop with a backward branch
		imm_op(op_addi, 12, 0, 16'd3, 32'd3);
		pad_nops(3);
		emit(itype_word(op_addi, 12, 12, 16'hFFFF));
		pad_nops(3);
		emit(itype_word(op_bne, 12, 0, 16'hFFFB));
		pad_nops(1);
		want_write(12, 32'd2);
		want_write(12, 32'd1);
		want_write(12, 32'd0);
		finish_test();
	endtask

	// Code is laid out out of order, emitted in execution order
	task automatic jumps();
		start_test("jump");
		emit(jump_word(op_j, 4));
		imm_op(op_addi, 1, 0, 16'd11, 32'd11);
		emit(itype_word(op_addi, 0, 2, 16'd66));
		emit(itype_word(op_addi, 0, 2, 16'd67));
		emit(jump_word(op_jal, 20));
		want_write(31, 32'(4 * 4 + 8));
		imm_op(op_addi, 3, 0, 16'd12, 32'd12);
		pc_idx = 20;
		imm_op(op_addi, 5, 0, 16'd14, 32'd14);
		pad_nops(2);
		emit(jreg_word(op_jr, 31, 0));
		imm_op(op_addi, 6, 0, 16'd15, 32'd15);
		pc_idx = 6;
		imm_op(op_addi, 4, 0, 16'd13, 32'd13);
		imm_op(op_addi, 9, 0, 16'(30 * 4), 32'(30 * 4));
		pad_nops(3);
		emit(jreg_word(op_jalr, 9, 10));
		want_write(10, 32'(11 * 4 + 8));
		imm_op(op_addi, 11, 0, 16'd16, 32'd16);
		pc_idx = 30;
		imm_op(op_addi, 12, 0, 16'd17, 32'd17);
		pad_nops(2);
		emit(jreg_word(op_jr, 10, 0));
		imm_op(op_addi, 13, 0, 16'd18, 32'd18);
		pc_idx = 13;
		imm_op(op_addi, 14, 0, 16'd19, 32'd19);
		finish_test();
	endtask

	task automatic zero_register();
		start_test("reg_zero");
		imm_op(op_addi, 0, 0, 16'd55, 32'd55);
		imm_op(op_ori, 0, 0, 16'hFFFF, 32'h0000_FFFF);
		imm_op(op_addi, 1, 0, 16'd100, 32'd100);
		pad_nops(3);
		reg_op(fn_add, 2, 1, 0, 0, 32'd100);
		reg_op(fn_add, 3, 0, 1, 0, 32'd100);
		reg_op(fn_or, 4, 0, 0, 0, 32'd0);
		finish_test();
	endtask

	// Each register is rewritten every fourth instruction from its own value
	task automatic random_immediates();
		logic [31:0] model [1:4];
		logic [15:0] imm;
		int          sel;
		int          r;
		int          i;
		start_test("random");
		for (r = 1; r <= 4; r++) begin
			imm = 16'($random(seed));
			model[r] = {{16{imm[15]}}, imm};
			imm_op(op_addi, 5'(r), 0, imm, model[r]);
		end
		for (i = 0; i < 20; i++) begin
			r = i % 4 + 1;
			imm = 16'($random(seed));
			sel = ($random(seed) & 32'h7FFF_FFFF) % 3;
			case (sel)
				0: begin
					model[r] = model[r] + {{16{imm[15]}}, imm};
					imm_op(op_addi, 5'(r), 5'(r), imm, model[r]);
				end
				1: begin
					model[r] = model[r] | {16'h0000, imm};
					imm_op(op_ori, 5'(r), 5'(r), imm, model[r]);
				end
				default: begin
					model[r] = model[r] & {16'h0000, imm};
					imm_op(op_andi, 5'(r), 5'(r), imm, model[r]);
				end
			endcase
		end
		finish_test();
	endtask

	initial begin
		seed = 7445;
		clk = 1'b0;
		rst = 1'b1;
		cycles = 0;
		pc_idx = 0;
		got_count = 0;
		foreach (prog[i]) prog[i] = nop_word;
		alu_ops();
		memory_access();
		cond_branches();
		jumps();
		zero_register();
		random_immediates();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/cpu_pkg.sv
source/cpu_if.sv
source/cpu_id.sv
source/cpu_ex.sv
source/cpu_mem.sv
source/cpu_top.sv
sim/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - source/cpu_pkg.sv
  - source/cpu_if.sv
  - source/cpu_id.sv
  - source/cpu_ex.sv
  - source/cpu_mem.sv
  - source/cpu_top.sv
  - target: test
    files:
      - sim/cpu_tb.sv
